// ==== tb.f ====
+incdir+design
design/memPkg.sv
design/fetchPkg.sv
design/icacheIf.sv
design/icacheArrays.sv
design/icacheFlushCtrl.sv
design/fetchPipeline.sv
design/fetchQueue.sv
design/fetchTop.sv
tests/fetchTb.sv

// ==== tests/fetchTb.sv ====
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetchTb;
    import fetchPkg::*;
    import memPkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int TEST_COUNT = 6;
    localparam int DRIVE_DELAY = 10;

    logic clk;
    logic rst;
    logic fetchValid;
    pc_t fetchPc;
    logic mispredict;
    logic clearCache;
    logic fillValid;
    memWord_t fillData;
    logic outReady;
    logic stall;
    logic redirect;
    pc_t redirectPc;
    logic fillReq;
    lineAddr_t fillAddr;
    logic outValid;
    pc_t outPc;
    instr_t outInstr0;
    instr_t outInstr1;

    int errorCount;
    int passCount;
    int failCount;
    logic [31:0] lfsrState;
    pc_t lineA;
    pc_t pcA;
    pc_t expectedPcs[$];

    fetchTop fetchTop_i (
        .clk(clk),
        .rst(rst),
        .fetchValid(fetchValid),
        .fetchPc(fetchPc),
        .mispredict(mispredict),
        .clearCache(clearCache),
        .fillValid(fillValid),
        .fillData(fillData),
        .outReady(outReady),
        .stall(stall),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .fillReq(fillReq),
        .fillAddr(fillAddr),
        .outValid(outValid),
        .outPc(outPc),
        .outInstr0(outInstr0),
        .outInstr1(outInstr1)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] result;
        logic outBit;
        result = '0;
        for (int i = 0; i < n; i++) begin
            outBit = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (outBit) begin
                lfsrState = lfsrState ^ 32'h80200003;
            end
            result = {result[30:0], outBit};
        end
        return result;
    endfunction

    function automatic pc_t lineBase(input setIdx_t set);
        logic [31:0] r;
        r = randomBits(TAG_BITS);
        return {r[TAG_BITS-1:0], set, {LINE_OFFSET_BITS{1'b0}}};
    endfunction

    // memory word held at a byte address
    function automatic memWord_t memWord(input logic [31:0] addr);
        return addr ^ 32'h5a5a0000;
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            errorCount++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic reportFailure(input string msg);
        errorCount++;
        $display("%0t ns: %s", $time, msg);
    endtask

    task automatic finishTest(input string name, input int startErrors);
        if (errorCount == startErrors) begin
            passCount++;
            $display("PASS  %s", name);
        end else begin
            failCount++;
            $display("FAIL  %s with %0d errors", name, errorCount - startErrors);
        end
    endtask

    task automatic waitStallLow(input int limit);
        int n;
        n = 0;
        while (stall && n < limit) begin
            nextCycle();
            n++;
        end
        if (stall) begin
            reportFailure("stall stayed high, fetch never resumed");
        end
    endtask

    // returns just after the accepting edge
    task automatic issueFetch(input pc_t pc);
        waitStallLow(100);
        fetchValid = 1'b1;
        fetchPc = pc;
        nextCycle();
        fetchValid = 1'b0;
    endtask

    task automatic checkPacket(input pc_t pc);
        pc_t base;
        base = {pc[31:3], 3'b000};
        checkValue("outPc", outPc, base);
        checkValue("outInstr0", outInstr0, memWord(base));
        checkValue("outInstr1", outInstr1, memWord(base + 32'd4));
    endtask

    task automatic expectHit(input pc_t pc);
        issueFetch(pc);
        nextCycle();
        if (outValid) begin
            reportFailure("packet appeared one cycle after acceptance");
        end
        nextCycle();
        if (redirect) begin
            reportFailure("cached pc caused a redirect");
        end
        if (!outValid) begin
            reportFailure("no packet two cycles after acceptance");
        end else begin
            checkPacket(pc);
        end
        nextCycle();
    endtask

    task automatic expectMiss(input pc_t pc);
        int sawRedirect;
        int sawFill;
        sawRedirect = 0;
        sawFill = 0;
        issueFetch(pc);
        for (int i = 0; i < 40; i++) begin
            nextCycle();
            if (outValid) begin
                reportFailure("packet delivered for a missing pc");
            end
            if (redirect !== fillReq) begin
                reportFailure("redirect and fillReq did not pulse together");
            end
            if (redirect) begin
                sawRedirect++;
                checkValue("redirectPc", redirectPc, pc);
            end
            if (fillReq) begin
                sawFill++;
                checkValue("fillAddr", fillAddr, pc[31:LINE_OFFSET_BITS]);
            end
            if (sawRedirect > 0 && !stall) begin
                break;
            end
        end
        if (sawRedirect != 1) begin
            reportFailure("redirect did not pulse exactly once on a miss");
        end
        if (sawFill != 1) begin
            reportFailure("fillReq did not pulse exactly once on a miss");
        end
        if (stall) begin
            reportFailure("stall still high after the line fill");
        end
    endtask

    // hits to both blocks of one line until stall rises
    task automatic fillQueueStalled(input pc_t base);
        int k;
        k = 0;
        waitStallLow(100);
        while (!stall && k < 20) begin
            fetchValid = 1'b1;
            fetchPc = base | (pc_t'(k[0]) << 3);
            expectedPcs.push_back(fetchPc);
            k++;
            nextCycle();
        end
        fetchValid = 1'b0;
        if (!stall) begin
            reportFailure("stall never rose under back-pressure");
        end
    endtask

    // answers each fillReq three cycles later with four words
    initial begin
        lineAddr_t reqAddr;
        fillValid = 1'b0;
        fillData = '0;
        forever begin
            nextCycle();
            if (fillReq) begin
                reqAddr = fillAddr;
                repeat (3) @(posedge clk);
                #DRIVE_DELAY;
                for (int w = 0; w < `LINE_WORDS; w++) begin
                    fillValid = 1'b1;
                    fillData = memWord({reqAddr, {LINE_OFFSET_BITS{1'b0}}} + 32'(4 * w));
                    nextCycle();
                end
                fillValid = 1'b0;
            end
        end
    end

    task automatic coldMiss();
        int startErrors;
        startErrors = errorCount;
        checkValue("redirect", 32'(redirect), 32'd0);
        checkValue("fillReq", 32'(fillReq), 32'd0);
        checkValue("outValid", 32'(outValid), 32'd0);
        checkValue("stall", 32'(stall), 32'd1);
        expectMiss(pcA);
        finishTest("cold miss", startErrors);
    endtask

    task automatic hitAfterFill();
        int startErrors;
        startErrors = errorCount;
        expectHit(pcA);
        expectHit(pcA ^ 32'h8);
        finishTest("hit after fill", startErrors);
    endtask

    task automatic backPressure();
        int startErrors;
        pc_t expected;
        startErrors = errorCount;
        outReady = 1'b0;
        expectedPcs.delete();
        fillQueueStalled(lineA);
        repeat (4) begin
            nextCycle();
            if (!outValid) begin
                reportFailure("queue lost its packets while outReady was low");
            end
        end
        outReady = 1'b1;
        repeat (12) begin
            if (outValid) begin
                if (expectedPcs.size() == 0) begin
                    reportFailure("extra packet after the queue drained");
                end else begin
                    expected = expectedPcs.pop_front();
                    checkPacket(expected);
                end
            end
            nextCycle();
        end
        if (expectedPcs.size() != 0) begin
            reportFailure("packets were lost under back-pressure");
        end
        finishTest("back-pressure", startErrors);
    endtask

    task automatic mispredictFlush();
        int startErrors;
        startErrors = errorCount;
        outReady = 1'b0;
        expectedPcs.delete();
        fillQueueStalled(lineA);
        if (!outValid) begin
            reportFailure("queue empty before mispredict");
        end
        mispredict = 1'b1;
        nextCycle();
        mispredict = 1'b0;
        if (outValid) begin
            reportFailure("outValid still high after mispredict");
        end
        outReady = 1'b1;
        repeat (8) begin
            nextCycle();
            if (outValid) begin
                reportFailure("stale packet delivered after mispredict");
            end
        end
        expectedPcs.delete();
        // fetch must resume cleanly afterwards
        expectHit(lineA | 32'h8);
        finishTest("mispredict", startErrors);
    endtask

    task automatic clearCacheRefill();
        int startErrors;
        startErrors = errorCount;
        clearCache = 1'b1;
        nextCycle();
        clearCache = 1'b0;
        if (!stall) begin
            reportFailure("stall did not rise for the cache flush");
        end
        waitStallLow(100);
        expectMiss(pcA);
        finishTest("clear cache", startErrors);
    endtask

    task automatic roundRobinReplace();
        int startErrors;
        setIdx_t set;
        pc_t lineX;
        pc_t lineY;
        pc_t lineZ;
        startErrors = errorCount;
        set = setIdx_t'(lineA[LINE_OFFSET_BITS +: SET_BITS] + 3);
        lineX = lineBase(set);
        lineY = lineBase(set);
        lineZ = lineBase(set);
        expectMiss(lineX);
        expectMiss(lineY);
        // third line evicts the first
        expectMiss(lineZ);
        expectHit(lineY);
        expectHit(lineZ | 32'h8);
        expectMiss(lineX);
        finishTest("replacement", startErrors);
    endtask

    initial begin
        #(TEST_COUNT * 400 * CLK_PERIOD);
        $display("watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

    initial begin
        errorCount = 0;
        passCount = 0;
        failCount = 0;
        lfsrState = 32'hd7f95455;
        rst = 1'b1;
        fetchValid = 1'b0;
        fetchPc = '0;
        mispredict = 1'b0;
        clearCache = 1'b0;
        outReady = 1'b1;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        lineA = lineBase(setIdx_t'(randomBits(SET_BITS)));
        pcA = lineA | (pc_t'(randomBits(1)) << 3);

        coldMiss();
        hitAfterFill();
        backPressure();
        mispredictFlush();
        clearCacheRefill();
        roundRobinReplace();

        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 TEST_COUNT, passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== design/fetchTop.sv ====
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetchTop (
    input logic clk,
    input logic rst,
    input logic fetchValid,
    input fetchPkg::pc_t fetchPc,
    input logic mispredict,
    input logic clearCache,
    input logic fillValid,
    input memPkg::memWord_t fillData,
    input logic outReady,
    output logic stall,
    output logic redirect,
    output fetchPkg::pc_t redirectPc,
    output logic fillReq,
    output memPkg::lineAddr_t fillAddr,
    output logic outValid,
    output fetchPkg::pc_t outPc,
    output fetchPkg::instr_t outInstr0,
    output fetchPkg::instr_t outInstr1
);
    import fetchPkg::*;

    icacheIf cacheBus ();

    logic flushing;
    logic sweepWe;
    way_t sweepWay;
    setIdx_t sweepSet;
    logic pipeBusy;
    logic fillPending;
    logic pushValid;
    fetchPacket_t pushPacket;
    fetchPacket_t outPacket;
    logic [$clog2(`FETCHQ_DEPTH):0] queueFree;

    fetchPipeline fetchPipeline_i (
        .clk(clk),
        .rst(rst),
        .fetchValid(fetchValid),
        .fetchPc(fetchPc),
        .mispredict(mispredict),
        .flushing(flushing),
        .sweepWe(sweepWe),
        .sweepWay(sweepWay),
        .sweepSet(sweepSet),
        .fillValid(fillValid),
        .fillData(fillData),
        .queueFree(queueFree),
        .stall(stall),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .fillReq(fillReq),
        .fillAddr(fillAddr),
        .pipeBusy(pipeBusy),
        .fillPending(fillPending),
        .pushValid(pushValid),
        .pushPacket(pushPacket),
        .cache(cacheBus.host)
    );

    icacheArrays icacheArrays_i (
        .clk(clk),
        .rst(rst),
        .cache(cacheBus.arrays)
    );

    icacheFlushCtrl icacheFlushCtrl_i (
        .clk(clk),
        .rst(rst),
        .clearCache(clearCache),
        .pipeBusy(pipeBusy),
        .fillPending(fillPending),
        .flushing(flushing),
        .sweepWe(sweepWe),
        .sweepWay(sweepWay),
        .sweepSet(sweepSet)
    );

    // mispredict discards whatever is waiting for the decoder
    fetchQueue fetchQueue_i (
        .clk(clk),
        .rst(rst),
        .clear(mispredict),
        .pushValid(pushValid),
        .pushPacket(pushPacket),
        .outReady(outReady),
        .outValid(outValid),
        .outPacket(outPacket),
        .free(queueFree)
    );

    assign outPc = outPacket.pc;
    assign outInstr0 = outPacket.instrs[0];
    assign outInstr1 = outPacket.instrs[1];

endmodule

// ==== design/fetchQueue.sv ====
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetchQueue (
    input logic clk,
    input logic rst,
    input logic clear,
    input logic pushValid,
    input fetchPkg::fetchPacket_t pushPacket,
    input logic outReady,
    output logic outValid,
    output fetchPkg::fetchPacket_t outPacket,
    output logic [$clog2(`FETCHQ_DEPTH):0] free
);
    import fetchPkg::*;

    localparam int PTR_BITS = $clog2(`FETCHQ_DEPTH);

    fetchPacket_t entries [`FETCHQ_DEPTH];
    logic [PTR_BITS-1:0] rdPtr;
    logic [PTR_BITS-1:0] wrPtr;
    logic [PTR_BITS:0] count;
    logic doPush;
    logic doPop;

    assign outValid = (count != '0);
    assign outPacket = entries[rdPtr];
    assign free = (PTR_BITS + 1)'(`FETCHQ_DEPTH) - count;

    assign doPush = pushValid && (count != (PTR_BITS + 1)'(`FETCHQ_DEPTH));
    assign doPop = outValid && outReady;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else if (clear) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + doPush - doPop;
        end
    end

    always_ff @(posedge clk) begin
        if (doPush && !clear) begin
            entries[wrPtr] <= pushPacket;
        end
    end

endmodule

// ==== design/fetchPipeline.sv ====
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetchPipeline (
    input logic clk,
    input logic rst,
    input logic fetchValid,
    input fetchPkg::pc_t fetchPc,
    input logic mispredict,
    input logic flushing,
    input logic sweepWe,
    input fetchPkg::way_t sweepWay,
    input fetchPkg::setIdx_t sweepSet,
    input logic fillValid,
    input memPkg::memWord_t fillData,
    input logic [$clog2(`FETCHQ_DEPTH):0] queueFree,
    output logic stall,
    output logic redirect,
    output fetchPkg::pc_t redirectPc,
    output logic fillReq,
    output memPkg::lineAddr_t fillAddr,
    output logic pipeBusy,
    output logic fillPending,
    output logic pushValid,
    output fetchPkg::fetchPacket_t pushPacket,
    icacheIf.host cache
);
    import fetchPkg::*;
    import memPkg::*;

    logic s0Valid;
    logic s1Valid;
    pc_t s0Pc;
    pc_t s1Pc;
    tag_t s1Tag;

    logic accept;
    logic [`ICACHE_WAYS-1:0] hitVec;
    way_t hitWay;
    logic cacheHit;
    logic cacheMiss;

    logic missPending;
    way_t missWay;
    way_t rrWay;
    wordIdx_t wordCnt;
    logic fillWrite;
    logic fillLast;

    assign accept = fetchValid && !stall;
    assign pipeBusy = s0Valid || s1Valid;
    assign fillPending = missPending;

    always_comb begin
        int roomLeft;
        roomLeft = int'(queueFree) - int'(s0Valid) - int'(s1Valid);
        stall = flushing || missPending || (roomLeft < 1);
    end

    // tag compare on the registered array outputs
    assign s1Tag = s1Pc[$bits(pc_t)-1 -: TAG_BITS];

    always_comb begin
        hitWay = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hitVec[w] = cache.rdValid[w] && (cache.rdTag[w] == s1Tag);
            if (hitVec[w]) begin
                hitWay = way_t'(w);
            end
        end
    end

    assign cacheHit = |hitVec;
    // a wrong-path miss is not worth a refill
    assign cacheMiss = s1Valid && !cacheHit && !mispredict;
    assign pushValid = s1Valid && cacheHit;

    always_comb begin
        wordIdx_t baseWord;
        baseWord = wordIdx_t'(s1Pc[LINE_OFFSET_BITS-1:BLOCK_OFFSET_BITS]) << $clog2(`BLOCK_WORDS);
        pushPacket.pc = {s1Pc[31:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};
        for (int i = 0; i < `BLOCK_WORDS; i++) begin
            pushPacket.instrs[i] = instr_t'(cache.rdData[hitWay][baseWord + wordIdx_t'(i)]);
        end
    end

    assign fillWrite = missPending && fillValid;
    assign fillLast = fillWrite && (wordCnt == wordIdx_t'(`LINE_WORDS - 1));

    always_comb begin
        cache.re = s0Valid;
        cache.rSet = s0Pc[LINE_OFFSET_BITS +: SET_BITS];

        cache.dataWe = fillWrite;
        cache.dataWay = missWay;
        cache.dataSet = fillAddr[SET_BITS-1:0];
        cache.dataWord = wordCnt;
        cache.dataWdata = fillData;

        // sweep wins the tag port
        if (sweepWe) begin
            cache.tagWe = 1'b1;
            cache.tagWay = sweepWay;
            cache.tagSet = sweepSet;
            cache.tagData = '0;
            cache.tagValid = 1'b0;
        end else begin
            cache.tagWe = fillLast;
            cache.tagWay = missWay;
            cache.tagSet = fillAddr[SET_BITS-1:0];
            cache.tagData = fillAddr[$bits(lineAddr_t)-1 -: TAG_BITS];
            cache.tagValid = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s0Valid <= 1'b0;
            s1Valid <= 1'b0;
            redirect <= 1'b0;
            fillReq <= 1'b0;
            missPending <= 1'b0;
            wordCnt <= '0;
            rrWay <= '0;
        end else begin
            redirect <= cacheMiss;
            fillReq <= cacheMiss;
            if (mispredict || cacheMiss) begin
                s0Valid <= 1'b0;
                s1Valid <= 1'b0;
            end else begin
                s0Valid <= accept;
                s1Valid <= s0Valid;
            end

            if (cacheMiss) begin
                missPending <= 1'b1;
                wordCnt <= '0;
            end
            if (fillWrite) begin
                wordCnt <= wordCnt + 1'b1;
                if (fillLast) begin
                    missPending <= 1'b0;
                    rrWay <= way_t'(rrWay + 1'b1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s0Pc <= fetchPc;
        end
        s1Pc <= s0Pc;
        // victim way is fixed when the miss is taken
        if (cacheMiss) begin
            redirectPc <= s1Pc;
            fillAddr <= s1Pc[31:LINE_OFFSET_BITS];
            missWay <= rrWay;
        end
    end

endmodule

// ==== design/icacheFlushCtrl.sv ====
`timescale 1ns/1ns
`include "fetch_defs.svh"

module icacheFlushCtrl (
    input logic clk,
    input logic rst,
    input logic clearCache,
    input logic pipeBusy,
    input logic fillPending,
    output logic flushing,
    output logic sweepWe,
    output fetchPkg::way_t sweepWay,
    output fetchPkg::setIdx_t sweepSet
);
    import fetchPkg::*;

    localparam int CNT_BITS = $clog2(`FLUSH_CYCLES);

    flushState_t state;
    logic [CNT_BITS-1:0] sweepCnt;
    logic [CNT_BITS-1:0] sweepNext;
    logic sweepCarry;

    // way in the upper bits, set in the lower bits
    assign {sweepCarry, sweepNext} = sweepCnt + 1'b1;
    assign sweepWay = sweepCnt[$bits(setIdx_t) +: $bits(way_t)];
    assign sweepSet = sweepCnt[$bits(setIdx_t)-1:0];

    assign flushing = (state != FLUSH_IDLE);
    assign sweepWe = (state == FLUSH_ACTIVE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FLUSH_QUEUED;
            sweepCnt <= '0;
        end else begin
            case (state)
                FLUSH_IDLE: begin
                    sweepCnt <= '0;
                    if (clearCache) begin
                        state <= FLUSH_QUEUED;
                    end
                end
                FLUSH_QUEUED: begin
                    sweepCnt <= '0;
                    // let requests in flight drain first
                    if (!pipeBusy) begin
                        state <= FLUSH_ACTIVE;
                    end
                end
                FLUSH_ACTIVE: begin
                    sweepCnt <= sweepNext;
                    if (sweepCarry) begin
                        state <= fillPending ? FLUSH_FINALIZE : FLUSH_IDLE;
                    end
                end
                default: begin
                    if (!fillPending) begin
                        state <= FLUSH_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== design/icacheArrays.sv ====
`timescale 1ns/1ns
`include "fetch_defs.svh"

module icacheArrays (
    input logic clk,
    input logic rst,
    icacheIf.arrays cache
);
    import fetchPkg::*;
    import memPkg::*;

    logic [`ICACHE_SETS-1:0] validBits [`ICACHE_WAYS];
    tag_t tagMem [`ICACHE_WAYS][`ICACHE_SETS];
    memWord_t [`LINE_WORDS-1:0] dataMem [`ICACHE_WAYS][`ICACHE_SETS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                validBits[w] <= '0;
            end
        end else if (cache.tagWe) begin
            validBits[cache.tagWay][cache.tagSet] <= cache.tagValid;
        end
    end

    always_ff @(posedge clk) begin
        if (cache.tagWe) begin
            tagMem[cache.tagWay][cache.tagSet] <= cache.tagData;
        end
        // fill writes land one word at a time
        if (cache.dataWe) begin
            dataMem[cache.dataWay][cache.dataSet][cache.dataWord] <= cache.dataWdata;
        end
    end

    // both ways of the set are read in parallel
    always_ff @(posedge clk) begin
        if (cache.re) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                cache.rdTag[w] <= tagMem[w][cache.rSet];
                cache.rdValid[w] <= validBits[w][cache.rSet];
                cache.rdData[w] <= dataMem[w][cache.rSet];
            end
        end
    end

endmodule

// ==== design/icacheIf.sv ====
`timescale 1ns/1ns
`include "fetch_defs.svh"

interface icacheIf;
    import fetchPkg::*;
    import memPkg::*;

    logic re;
    setIdx_t rSet;

    logic tagWe;
    way_t tagWay;
    setIdx_t tagSet;
    tag_t tagData;
    logic tagValid;

    logic dataWe;
    way_t dataWay;
    setIdx_t dataSet;
    wordIdx_t dataWord;
    memWord_t dataWdata;

    // registered read results of all ways side by side
    tag_t [`ICACHE_WAYS-1:0] rdTag;
    logic [`ICACHE_WAYS-1:0] rdValid;
    memWord_t [`ICACHE_WAYS-1:0][`LINE_WORDS-1:0] rdData;

    modport arrays (
        input re, rSet,
        input tagWe, tagWay, tagSet, tagData, tagValid,
        input dataWe, dataWay, dataSet, dataWord, dataWdata,
        output rdTag, rdValid, rdData
    );

    modport host (
        output re, rSet,
        output tagWe, tagWay, tagSet, tagData, tagValid,
        output dataWe, dataWay, dataSet, dataWord, dataWdata,
        input rdTag, rdValid, rdData
    );

endinterface

// ==== design/fetchPkg.sv ====
package fetchPkg;

    `include "fetch_defs.svh"

    localparam int SET_BITS = $clog2(`ICACHE_SETS);
    localparam int TAG_BITS = 32 - SET_BITS - memPkg::LINE_OFFSET_BITS;
    // byte offset within a fetch block
    localparam int BLOCK_OFFSET_BITS = $clog2(`BLOCK_WORDS) + 2;

    typedef logic [31:0] pc_t;
    typedef logic [31:0] instr_t;
    typedef logic [SET_BITS-1:0] setIdx_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;

    typedef struct packed {
        pc_t pc;
        instr_t [`BLOCK_WORDS-1:0] instrs;
    } fetchPacket_t;

    typedef enum logic [1:0] {
        FLUSH_IDLE,
        FLUSH_QUEUED,
        FLUSH_ACTIVE,
        FLUSH_FINALIZE
    } flushState_t;

endpackage

// ==== design/memPkg.sv ====
package memPkg;

    `include "fetch_defs.svh"

    localparam int WORD_IDX_BITS = $clog2(`LINE_WORDS);
    // byte offset within a cache line
    localparam int LINE_OFFSET_BITS = WORD_IDX_BITS + 2;

    typedef logic [31-LINE_OFFSET_BITS:0] lineAddr_t;
    typedef logic [31:0] memWord_t;
    typedef logic [WORD_IDX_BITS-1:0] wordIdx_t;

endpackage

// ==== design/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// instruction cache geometry
`define ICACHE_WAYS 2
`define ICACHE_SETS 8
`define LINE_WORDS 4

// instructions handed to the decoder per fetch block
`define BLOCK_WORDS 2

`define FETCHQ_DEPTH 4

// one tag invalidated per cycle
`define FLUSH_CYCLES 16

`endif
